//--- source/hk_spi_pkg.sv
package hk_spi_pkg;

    // ----------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------

    // Serial byte, read data and write data
    typedef logic [7:0]  spi_byte_t;
    typedef logic [7:0]  reg_addr_t;
    // Bit position inside the current byte
    typedef logic [2:0]  bit_cnt_t;
    // Byte count from the command, zero selects streaming
    typedef logic [2:0]  xfer_cnt_t;
    typedef logic [25:0] pll_trim_t;
    typedef logic [4:0]  pll_div_t;
    typedef logic [2:0]  pll_sel_t;
    typedef logic [31:0] mask_rev_t;
    typedef logic [11:0] mfgr_id_t;

    // Frame phases, in order of arrival
    typedef enum logic [1:0] {
        CMD,
        ADDR,
        DATA
    } spi_state_t;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam reg_addr_t ADDR_STATUS  = 8'h00;
    localparam reg_addr_t ADDR_MFGR_HI = 8'h01;
    localparam reg_addr_t ADDR_MFGR_LO = 8'h02;
    localparam reg_addr_t ADDR_PROD    = 8'h03;
    // Mask revision, most significant byte first
    localparam reg_addr_t ADDR_MASK0   = 8'h04;
    localparam reg_addr_t ADDR_MASK1   = 8'h05;
    localparam reg_addr_t ADDR_MASK2   = 8'h06;
    localparam reg_addr_t ADDR_MASK3   = 8'h07;
    localparam reg_addr_t ADDR_PLL_ENA = 8'h08;
    localparam reg_addr_t ADDR_BYPASS  = 8'h09;
    localparam reg_addr_t ADDR_IRQ     = 8'h0a;
    localparam reg_addr_t ADDR_RESET   = 8'h0b;
    localparam reg_addr_t ADDR_TRAP    = 8'h0c;
    // PLL trim, least significant byte first
    localparam reg_addr_t ADDR_TRIM0   = 8'h0d;
    localparam reg_addr_t ADDR_TRIM1   = 8'h0e;
    localparam reg_addr_t ADDR_TRIM2   = 8'h0f;
    localparam reg_addr_t ADDR_TRIM3   = 8'h10;
    localparam reg_addr_t ADDR_PLL_SEL = 8'h11;
    localparam reg_addr_t ADDR_PLL_DIV = 8'h12;

    // ----------------------------------------
    // Reset values
    // ----------------------------------------
    // Near the slowest DCO rate, bit 12 must stay low for startup
    localparam pll_trim_t TRIM_RST    = 26'h3ffefff;
    localparam pll_sel_t  SEL_RST     = 3'd2;
    localparam pll_div_t  DIV_RST     = 5'd4;
    localparam logic      DCO_ENA_RST = 1'b1;
    localparam logic      PLL_ENA_RST = 1'b0;
    localparam logic      BYPASS_RST  = 1'b1;
    localparam logic      IRQ_RST     = 1'b0;
    localparam logic      RESET_RST   = 1'b0;

endpackage

//--- source/spi_frame_fsm.sv
module spi_frame_fsm
    import hk_spi_pkg::*;
(
    input  logic      SCK,
    input  logic      RSTB,
    input  logic      CSB,
    input  logic      SDI,
    output reg_addr_t addr,
    output spi_byte_t wdata,
    output logic      read_phase,
    output logic      byte_start,
    output logic      write_due
);

    spi_state_t state;
    bit_cnt_t   bit_cnt;
    logic       write_mode;
    logic       read_mode;
    xfer_cnt_t  xfer_cnt;
    reg_addr_t  addr_q;
    logic [6:0] data_q;
    logic       frame_rst_n;

    // Frame restarts whenever CSB is high or the chip reset is active
    assign frame_rst_n = RSTB & ~CSB;

    // ----------------------------------------
    // Rising-edge frame state machine
    // ----------------------------------------
    always_ff @(posedge SCK or negedge frame_rst_n) begin
        if (!frame_rst_n) begin
            state      <= CMD;
            bit_cnt    <= '0;
            write_mode <= 1'b0;
            read_mode  <= 1'b0;
            xfer_cnt   <= '0;
            addr_q     <= '0;
            data_q     <= '0;
        end else begin
            // Bit position runs freely, every phase is eight bits long
            bit_cnt <= bit_cnt + 3'd1;
            case (state)
                CMD: begin
                    case (bit_cnt)
                        3'd0: write_mode <= SDI;
                        3'd1: read_mode <= SDI;
                        // Byte count, three bits MSB first
                        3'd2, 3'd3, 3'd4: xfer_cnt <= {xfer_cnt[1:0], SDI};
                        // Low three command bits are reserved
                        3'd7: state <= ADDR;
                        default: ;
                    endcase
                end
                ADDR: begin
                    addr_q <= {addr_q[6:0], SDI};
                    if (bit_cnt == 3'd7) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    data_q <= {data_q[5:0], SDI};
                    if (bit_cnt == 3'd7) begin
                        if (xfer_cnt == 3'd1) begin
                            // Last byte of a fixed-count transfer
                            state <= CMD;
                        end else begin
                            if (xfer_cnt != '0) begin
                                xfer_cnt <= xfer_cnt - 3'd1;
                            end
                            // Auto increment, wraps past 0xff
                            addr_q <= addr_q + 8'd1;
                        end
                    end
                end
                default: state <= CMD;
            endcase
        end
    end

    // ----------------------------------------
    // Outputs to the bank and the shifter
    // ----------------------------------------

    // Address phase already shows the bit on SDI
    assign addr  = (state == ADDR) ? {addr_q[6:0], SDI} : addr_q;
    // Last data bit comes straight from SDI
    assign wdata = {data_q, SDI};

    assign read_phase = (state == DATA) && read_mode;
    assign byte_start = (state == DATA) && (bit_cnt == 3'd0);
    assign write_due  = (state == DATA) && (bit_cnt == 3'd7) && write_mode;

    // Data bytes only end in CMD or in another data byte
    a_no_data_to_addr: assert property (
        @(posedge SCK) disable iff (!frame_rst_n)
        (state == DATA) |=> (state != ADDR)
    );

    // Write mode comes from the command alone and holds until CMD
    a_write_mode_held: assert property (
        @(posedge SCK) disable iff (!frame_rst_n)
        (state != CMD) |=> $stable(write_mode)
    );

endmodule

//--- source/spi_shift_out.sv
module spi_shift_out
    import hk_spi_pkg::*;
(
    input  logic      SCK,
    input  logic      RSTB,
    input  logic      CSB,
    input  spi_byte_t rdata,
    input  logic      read_phase,
    input  logic      byte_start,
    input  logic      write_due,
    output logic      SDO,
    output logic      sdo_enb,
    output logic      wr_stb
);

    spi_byte_t ldata;
    logic      shift_rst_n;

    assign shift_rst_n = RSTB & ~CSB;

    // Falling edge keeps SDO stable for the master's rising-edge sample
    always_ff @(negedge SCK or negedge shift_rst_n) begin
        if (!shift_rst_n) begin
            ldata   <= '0;
            sdo_enb <= 1'b1;
            wr_stb  <= 1'b0;
        end else begin
            // Driver on only during read data bytes
            sdo_enb <= ~read_phase;
            if (read_phase && byte_start) begin
                // Old value, ahead of any write in the same byte
                ldata <= rdata;
            end else begin
                ldata <= {ldata[6:0], 1'b0};
            end
            // Strobe spans the rising edge of the last data bit
            wr_stb <= write_due;
        end
    end

    // MSB leaves first
    assign SDO = ldata[7];

    // One write per byte, so the strobe is always a single pulse
    a_wr_stb_pulse: assert property (
        @(negedge SCK) disable iff (!shift_rst_n)
        wr_stb |=> !wr_stb
    );

endmodule

//--- source/hk_register_bank.sv
module hk_register_bank
    import hk_spi_pkg::*;
#(
    parameter mfgr_id_t  MFGR_ID = 12'h456,
    parameter spi_byte_t PROD_ID = 8'h10
) (
    input  logic      SCK,
    input  logic      RSTB,
    input  reg_addr_t addr,
    input  spi_byte_t wdata,
    input  logic      wr_stb,
    input  logic      trap,
    input  mask_rev_t mask_rev,
    output spi_byte_t rdata,
    output logic      pll_ena,
    output logic      pll_dco_ena,
    output pll_div_t  pll_div,
    output pll_sel_t  pll_sel,
    output pll_sel_t  pll90_sel,
    output pll_trim_t pll_trim,
    output logic      pll_bypass,
    output logic      irq,
    output logic      reset
);

    // ----------------------------------------
    // Writable registers
    // ----------------------------------------
    always_ff @(posedge SCK or negedge RSTB) begin
        if (!RSTB) begin
            pll_trim    <= TRIM_RST;
            pll_sel     <= SEL_RST;
            pll90_sel   <= SEL_RST;
            pll_div     <= DIV_RST;
            pll_dco_ena <= DCO_ENA_RST;
            pll_ena     <= PLL_ENA_RST;
            pll_bypass  <= BYPASS_RST;
            irq         <= IRQ_RST;
            reset       <= RESET_RST;
        end else if (wr_stb) begin
            case (addr)
                ADDR_PLL_ENA: begin
                    pll_ena     <= wdata[0];
                    pll_dco_ena <= wdata[1];
                end
                ADDR_BYPASS: pll_bypass <= wdata[0];
                ADDR_IRQ:    irq <= wdata[0];
                ADDR_RESET:  reset <= wdata[0];
                // Trim word, low byte at the lowest address
                ADDR_TRIM0:  pll_trim[7:0] <= wdata;
                ADDR_TRIM1:  pll_trim[15:8] <= wdata;
                ADDR_TRIM2:  pll_trim[23:16] <= wdata;
                ADDR_TRIM3:  pll_trim[25:24] <= wdata[1:0];
                ADDR_PLL_SEL: begin
                    pll_sel   <= wdata[2:0];
                    pll90_sel <= wdata[5:3];
                end
                ADDR_PLL_DIV: pll_div <= wdata[4:0];
                // IDs, mask revision, trap and unmapped space are read only
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Read-back multiplexer
    // ----------------------------------------
    always_comb begin
        case (addr)
            // Status byte, nothing defined yet
            ADDR_STATUS:  rdata = 8'h00;
            ADDR_MFGR_HI: rdata = {4'h0, MFGR_ID[11:8]};
            ADDR_MFGR_LO: rdata = MFGR_ID[7:0];
            ADDR_PROD:    rdata = PROD_ID;
            // Mask revision from the metal straps
            ADDR_MASK0:   rdata = mask_rev[31:24];
            ADDR_MASK1:   rdata = mask_rev[23:16];
            ADDR_MASK2:   rdata = mask_rev[15:8];
            ADDR_MASK3:   rdata = mask_rev[7:0];
            ADDR_PLL_ENA: rdata = {6'b0, pll_dco_ena, pll_ena};
            ADDR_BYPASS:  rdata = {7'b0, pll_bypass};
            ADDR_IRQ:     rdata = {7'b0, irq};
            ADDR_RESET:   rdata = {7'b0, reset};
            ADDR_TRAP:    rdata = {7'b0, trap};
            ADDR_TRIM0:   rdata = pll_trim[7:0];
            ADDR_TRIM1:   rdata = pll_trim[15:8];
            ADDR_TRIM2:   rdata = pll_trim[23:16];
            ADDR_TRIM3:   rdata = {6'b0, pll_trim[25:24]};
            ADDR_PLL_SEL: rdata = {2'b0, pll90_sel, pll_sel};
            ADDR_PLL_DIV: rdata = {3'b0, pll_div};
            default:      rdata = 8'h00;
        endcase
    end

    // Shifter is held in reset with the bank, so no strobe can arrive
    a_no_stb_in_reset: assert property (
        @(posedge SCK) wr_stb |-> RSTB
    );

endmodule

//--- source/housekeeping_spi.sv
module housekeeping_spi
    import hk_spi_pkg::*;
#(
    parameter mfgr_id_t  MFGR_ID = 12'h456,
    parameter spi_byte_t PROD_ID = 8'h10
) (
    input  logic      SCK,
    input  logic      RSTB,
    input  logic      CSB,
    input  logic      SDI,
    input  logic      trap,
    input  mask_rev_t mask_rev_in,
    output logic      SDO,
    output logic      sdo_enb,
    output logic      pll_ena,
    output logic      pll_dco_ena,
    output pll_div_t  pll_div,
    output pll_sel_t  pll_sel,
    output pll_sel_t  pll90_sel,
    output pll_trim_t pll_trim,
    output logic      pll_bypass,
    output logic      irq,
    output logic      reset
);

    // ----------------------------------------
    // Internal frame and register signals
    // ----------------------------------------
    reg_addr_t addr;
    spi_byte_t wdata;
    spi_byte_t rdata;
    logic      read_phase;
    logic      byte_start;
    logic      write_due;
    logic      wr_stb;

    // Rising edge side, command and address decode
    spi_frame_fsm u_frame (
        .SCK        (SCK),
        .RSTB       (RSTB),
        .CSB        (CSB),
        .SDI        (SDI),
        .addr       (addr),
        .wdata      (wdata),
        .read_phase (read_phase),
        .byte_start (byte_start),
        .write_due  (write_due)
    );

    // Falling edge side, read data and write strobe
    spi_shift_out u_shift (
        .SCK        (SCK),
        .RSTB       (RSTB),
        .CSB        (CSB),
        .rdata      (rdata),
        .read_phase (read_phase),
        .byte_start (byte_start),
        .write_due  (write_due),
        .SDO        (SDO),
        .sdo_enb    (sdo_enb),
        .wr_stb     (wr_stb)
    );

    // Register map and outputs to the PLL and the SoC
    hk_register_bank #(
        .MFGR_ID (MFGR_ID),
        .PROD_ID (PROD_ID)
    ) u_bank (
        .SCK         (SCK),
        .RSTB        (RSTB),
        .addr        (addr),
        .wdata       (wdata),
        .wr_stb      (wr_stb),
        .trap        (trap),
        .mask_rev    (mask_rev_in),
        .rdata       (rdata),
        .pll_ena     (pll_ena),
        .pll_dco_ena (pll_dco_ena),
        .pll_div     (pll_div),
        .pll_sel     (pll_sel),
        .pll90_sel   (pll90_sel),
        .pll_trim    (pll_trim),
        .pll_bypass  (pll_bypass),
        .irq         (irq),
        .reset       (reset)
    );

endmodule

//--- testbench/hk_spi_model.svh
`ifndef HK_SPI_MODEL_SVH
`define HK_SPI_MODEL_SVH

// ----------------------------------------
// Image of the writable register fields
// ----------------------------------------
pll_trim_t m_trim;
pll_sel_t  m_sel;
pll_sel_t  m_sel90;
pll_div_t  m_div;
logic      m_dco_ena;
logic      m_pll_ena;
logic      m_bypass;
logic      m_irq;
logic      m_reset;

// Power-on values of the map
function automatic void model_reset();
    m_trim    = TRIM_RST;
    m_sel     = SEL_RST;
    m_sel90   = SEL_RST;
    m_div     = DIV_RST;
    m_dco_ena = DCO_ENA_RST;
    m_pll_ena = PLL_ENA_RST;
    m_bypass  = BYPASS_RST;
    m_irq     = IRQ_RST;
    m_reset   = RESET_RST;
endfunction

// One data byte landing at an address
function automatic void model_write(reg_addr_t a, spi_byte_t d);
    case (a)
        ADDR_PLL_ENA: begin
            m_pll_ena = d[0];
            m_dco_ena = d[1];
        end
        ADDR_BYPASS:  m_bypass = d[0];
        ADDR_IRQ:     m_irq = d[0];
        ADDR_RESET:   m_reset = d[0];
        ADDR_TRIM0:   m_trim[7:0] = d;
        ADDR_TRIM1:   m_trim[15:8] = d;
        ADDR_TRIM2:   m_trim[23:16] = d;
        ADDR_TRIM3:   m_trim[25:24] = d[1:0];
        ADDR_PLL_SEL: begin
            m_sel   = d[2:0];
            m_sel90 = d[5:3];
        end
        ADDR_PLL_DIV: m_div = d[4:0];
        // Read-only and unmapped addresses keep their value
        default: ;
    endcase
endfunction

// Reference value seen by a read at an address
function automatic spi_byte_t expected_byte(reg_addr_t a);
    spi_byte_t v;
    v = 8'h00;
    case (a)
        ADDR_MFGR_HI: v = {4'h0, MFGR_ID[11:8]};
        ADDR_MFGR_LO: v = MFGR_ID[7:0];
        ADDR_PROD:    v = PROD_ID;
        // Mask revision, top byte at the lowest address
        ADDR_MASK0:   v = mask_rev_in[31:24];
        ADDR_MASK1:   v = mask_rev_in[23:16];
        ADDR_MASK2:   v = mask_rev_in[15:8];
        ADDR_MASK3:   v = mask_rev_in[7:0];
        ADDR_PLL_ENA: v = {6'b0, m_dco_ena, m_pll_ena};
        ADDR_BYPASS:  v = {7'b0, m_bypass};
        ADDR_IRQ:     v = {7'b0, m_irq};
        ADDR_RESET:   v = {7'b0, m_reset};
        ADDR_TRAP:    v = {7'b0, trap};
        ADDR_TRIM0:   v = m_trim[7:0];
        ADDR_TRIM1:   v = m_trim[15:8];
        ADDR_TRIM2:   v = m_trim[23:16];
        ADDR_TRIM3:   v = {6'b0, m_trim[25:24]};
        ADDR_PLL_SEL: v = {2'b0, m_sel90, m_sel};
        ADDR_PLL_DIV: v = {3'b0, m_div};
        // Status and everything above the map read zero
        default:      v = 8'h00;
    endcase
    return v;
endfunction

`endif

//--- testbench/tb_housekeeping_spi.sv
module tb_housekeeping_spi
    import hk_spi_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam mfgr_id_t  MFGR_ID      = 12'h456;
    localparam spi_byte_t PROD_ID      = 8'h10;
    localparam int        RESET_CYCLES = 8;
    // Bits of every frame in the run, test by test
    localparam int        FRAME_BITS   = 184 + 88 + 2 * 104 + 24 + 20 + 24 + 104;

    logic      SCK;
    logic      RSTB;
    logic      CSB;
    logic      SDI;
    logic      trap;
    mask_rev_t mask_rev_in;
    logic      SDO;
    logic      sdo_enb;
    logic      pll_ena;
    logic      pll_dco_ena;
    pll_div_t  pll_div;
    pll_sel_t  pll_sel;
    pll_sel_t  pll90_sel;
    pll_trim_t pll_trim;
    logic      pll_bypass;
    logic      irq;
    logic      reset;

    integer    seed = 32'h3e571094;
    string     test_name = "reset";
    // Read bytes waiting for the compare process
    spi_byte_t exp_q[$];
    spi_byte_t act_q[$];
    string     name_q[$];
    // Write data for the next frame
    spi_byte_t tx_q[$];
    int        bytes_read = 0;
    int        bytes_checked = 0;

    `include "hk_spi_model.svh"

    housekeeping_spi #(
        .MFGR_ID (MFGR_ID),
        .PROD_ID (PROD_ID)
    ) DUT (
        .SCK         (SCK),
        .RSTB        (RSTB),
        .CSB         (CSB),
        .SDI         (SDI),
        .trap        (trap),
        .mask_rev_in (mask_rev_in),
        .SDO         (SDO),
        .sdo_enb     (sdo_enb),
        .pll_ena     (pll_ena),
        .pll_dco_ena (pll_dco_ena),
        .pll_div     (pll_div),
        .pll_sel     (pll_sel),
        .pll90_sel   (pll90_sel),
        .pll_trim    (pll_trim),
        .pll_bypass  (pll_bypass),
        .irq         (irq),
        .reset       (reset)
    );

    // 8 ns SPI clock
    initial begin : clock_gen
        SCK = 1'b0;
        forever #4 SCK = ~SCK;
    end

    // ----------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_trim(input string name, input pll_trim_t exp, input pll_trim_t act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_div(input string name, input pll_div_t exp, input pll_div_t act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_sel(input string name, input pll_sel_t exp, input pll_sel_t act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    endtask

    // Every output port against the model, only while CSB is high
    task automatic check_outputs();
        check_trim($sformatf("%s pll_trim", test_name), m_trim, pll_trim);
        check_sel($sformatf("%s pll_sel", test_name), m_sel, pll_sel);
        check_sel($sformatf("%s pll90_sel", test_name), m_sel90, pll90_sel);
        check_div($sformatf("%s pll_div", test_name), m_div, pll_div);
        check_bit($sformatf("%s pll_ena", test_name), m_pll_ena, pll_ena);
        check_bit($sformatf("%s pll_dco_ena", test_name), m_dco_ena, pll_dco_ena);
        check_bit($sformatf("%s pll_bypass", test_name), m_bypass, pll_bypass);
        check_bit($sformatf("%s irq", test_name), m_irq, irq);
        check_bit($sformatf("%s reset", test_name), m_reset, reset);
        // Idle SDO side
        check_bit($sformatf("%s sdo_enb", test_name), 1'b1, sdo_enb);
        check_bit($sformatf("%s SDO", test_name), 1'b0, SDO);
    endtask

    // ----------------------------------------
    // SPI master
    // ----------------------------------------

    // Top nbits of tx, MSB first, entered 1 ns after a rising edge
    task automatic shift_bits(input spi_byte_t tx, input int nbits, input logic rd,
                              output spi_byte_t rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            SDI = tx[i];
            @(posedge SCK);
            rx[i] = SDO;
            // Driver on only while read data leaves
            check_bit($sformatf("%s sdo_enb", test_name), ~rd, sdo_enb);
            #1;
        end
    endtask

    // Command, address and nbytes data bytes inside an open frame
    task automatic spi_cmd(input logic wr, input logic rd, input xfer_cnt_t cnt,
                           input reg_addr_t a, input int nbytes);
        spi_byte_t rx;
        spi_byte_t tx;
        spi_byte_t exp;
        reg_addr_t cur;
        cur = a;
        shift_bits({wr, rd, cnt, 3'b000}, 8, 1'b0, rx);
        shift_bits(a, 8, 1'b0, rx);
        for (int k = 0; k < nbytes; k++) begin
            if (wr)
                tx = tx_q.pop_front();
            else
                tx = 8'h00;
            // Read sees the value from before this byte's own write
            exp = expected_byte(cur);
            shift_bits(tx, 8, rd, rx);
            if (rd) begin
                exp_q.push_back(exp);
                act_q.push_back(rx);
                name_q.push_back($sformatf("%s addr %h", test_name, cur));
                bytes_read++;
            end
            if (wr)
                model_write(cur, tx);
            cur = cur + 8'd1;
        end
    endtask

    task automatic end_frame();
        CSB = 1'b1;
        SDI = 1'b0;
        repeat (2) @(posedge SCK);
        #1;
    endtask

    // Read bytes against the reference, away from the sampling edge
    initial begin : compare
        forever begin
            @(negedge SCK);
            while (act_q.size() > 0) begin
                check_byte(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
                bytes_checked++;
            end
        end
    end

    initial begin : watchdog
        #(2 * FRAME_BITS * 8 + RESET_CYCLES * 8);
        fail_run("Run timed out before all SPI frames completed");
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [31:0] rnd;
        spi_byte_t   rx;
        RSTB        = 1'b0;
        CSB         = 1'b1;
        SDI         = 1'b0;
        mask_rev_in = $random(seed);
        rnd         = $random(seed);
        trap        = rnd[0];
        model_reset();
        repeat (RESET_CYCLES) @(posedge SCK);
        #1;
        RSTB = 1'b1;
        check_outputs();

        // Whole map plus two unmapped bytes
        test_name = "read_map";
        CSB = 1'b0;
        spi_cmd(1'b0, 1'b1, 3'd0, ADDR_STATUS, 21);
        end_frame();

        // Fixed-count write then read in the same frame
        test_name = "trim_fixed";
        tx_q.push_back(8'ha5);
        tx_q.push_back(8'h3c);
        tx_q.push_back(8'h96);
        CSB = 1'b0;
        spi_cmd(1'b1, 1'b0, 3'd3, ADDR_TRIM0, 3);
        spi_cmd(1'b0, 1'b1, 3'd4, ADDR_TRIM0, 4);
        end_frame();
        check_outputs();

        // Random bytes over every writable field, trap included
        test_name = "stream_write";
        for (int k = 0; k < 11; k++) begin
            rnd = $random(seed);
            tx_q.push_back(rnd[7:0]);
        end
        CSB = 1'b0;
        spi_cmd(1'b1, 1'b0, 3'd0, ADDR_PLL_ENA, 11);
        end_frame();
        check_outputs();
        CSB = 1'b0;
        spi_cmd(1'b0, 1'b1, 3'd0, ADDR_PLL_ENA, 11);
        end_frame();

        // Inverted selects so old and new always differ
        test_name = "sel_rw";
        tx_q.push_back({2'b0, ~m_sel90, ~m_sel});
        CSB = 1'b0;
        spi_cmd(1'b1, 1'b1, 3'd1, ADDR_PLL_SEL, 1);
        end_frame();
        check_outputs();

        // Half a data byte, then CSB rises
        test_name = "abort";
        CSB = 1'b0;
        spi_cmd(1'b1, 1'b0, 3'd0, ADDR_PLL_DIV, 0);
        shift_bits(~{3'b0, m_div}, 4, 1'b0, rx);
        end_frame();
        check_outputs();
        CSB = 1'b0;
        spi_cmd(1'b0, 1'b1, 3'd1, ADDR_PLL_DIV, 1);
        end_frame();

        // Chip reset pulse while idle
        test_name = "rstb_pulse";
        RSTB = 1'b0;
        @(posedge SCK);
        #1;
        RSTB = 1'b1;
        model_reset();
        check_outputs();
        CSB = 1'b0;
        spi_cmd(1'b0, 1'b1, 3'd0, ADDR_PLL_ENA, 11);
        end_frame();

        repeat (2) @(posedge SCK);
        if (bytes_checked == bytes_read && act_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("Only %0d of %0d read bytes were compared",
                               bytes_checked, bytes_read));
        end
    end

endmodule

//--- housekeeping_spi.f
+incdir+testbench
source/hk_spi_pkg.sv
source/spi_frame_fsm.sv
source/spi_shift_out.sv
source/hk_register_bank.sv
source/housekeeping_spi.sv
testbench/tb_housekeeping_spi.sv

//--- Bender.yml
package:
  name: housekeeping_spi

sources:
  - source/hk_spi_pkg.sv
  - source/spi_frame_fsm.sv
  - source/spi_shift_out.sv
  - source/hk_register_bank.sv
  - source/housekeeping_spi.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_housekeeping_spi.sv
